//--- hdl/btc_buf_if.sv
// BTC buffer write and read interfaces
`timescale 1ns/1ns

// --------------------------------------
// Writer to buffer
// --------------------------------------

interface btc_buf_wr_if;
  // Bit write, one per strobe
  logic                          wval;
  btc_buf_pkg::btc_addr_u        waddr;
  logic                          wdat;
  // Last bit of block, descriptor valid here
  logic                          wdone;
  logic [btc_buf_pkg::cTAG_W-1:0] wtag;
  logic [btc_buf_pkg::cERR_W-1:0] werr;
  logic                          wdecfail;
  // Buffer holds an unread block
  logic                          full;

  modport writer (output wval, waddr, wdat, wdone, wtag, werr, wdecfail, input full);
  modport buffer (input wval, waddr, wdat, wdone, wtag, werr, wdecfail, output full);
endinterface

// --------------------------------------
// Buffer to sink
// --------------------------------------

interface btc_buf_rd_if;
  logic                          rfull;
  logic                          rdat;
  logic [btc_buf_pkg::cTAG_W-1:0] rtag;
  logic [btc_buf_pkg::cERR_W-1:0] rerr;
  logic                          rdecfail;
  // Read address, data follows cRD_LAT cycles later
  btc_buf_pkg::btc_addr_u        raddr;
  // Block consumed, releases the buffer
  logic                          rempty;

  modport buffer (output rfull, rdat, rtag, rerr, rdecfail, input raddr, rempty);
  modport sink   (input rfull, rdat, rtag, rerr, rdecfail, output raddr, rempty);
endinterface

//--- hdl/btc_buf_pkg.sv
// BTC output buffer definitions

package btc_buf_pkg;

  // Buffer address width, one bit per word
  localparam int cRADDR_W = 10;

  // Block descriptor widths
  localparam int cTAG_W = 8;
  localparam int cERR_W = 16;

  // Address to data, in clock cycles
  localparam int cRD_LAT = 2;

  // --------------------------------------
  // Buffer address word
  // --------------------------------------

  // Flat index for the writer, row/col pair for the sink
  // Row in the upper bits, so rows are 32 words apart
  typedef union packed {
    logic [cRADDR_W-1:0] raw;
    struct packed {
      logic [btc_mode_pkg::cLOG2_ROW_MAX-1:0] row;
      logic [btc_mode_pkg::cLOG2_COL_MAX-1:0] col;
    } rc;
  } btc_addr_u;

endpackage

//--- hdl/btc_buf_writer.sv
// BTC result buffer writer
`timescale 1ns/1ns

module btc_buf_writer (
  input  logic                           iclk,
  input  logic                           ireset,
  input  logic                           iclkena,
  input  btc_mode_pkg::btc_code_mode_t   ixmode,
  input  btc_mode_pkg::btc_code_mode_t   iymode,
  input  logic                           ival,
  input  logic                           ibit,
  input  logic                           ihard,
  input  logic                           idecfail,
  input  logic [btc_buf_pkg::cTAG_W-1:0] itag,
  output logic                           ordy,
  btc_buf_wr_if.writer                   wr
);

  logic [btc_mode_pkg::cLOG2_COL_MAX-1:0] col_cnt;
  logic [btc_mode_pkg::cLOG2_ROW_MAX-1:0] row_cnt;
  logic                                   col_last;
  logic                                   row_last;
  logic                                   first_bit;
  btc_buf_pkg::btc_addr_u                 addr;
  logic [btc_buf_pkg::cERR_W-1:0]         err_inc;

  // --------------------------------------
  // Position in the block
  // --------------------------------------

  // Row length from x mode, row count from y mode
  assign col_last  = (col_cnt == btc_mode_pkg::cDATA_BITS[ixmode] - 5'd1);
  assign row_last  = (row_cnt == btc_mode_pkg::cDATA_BITS[iymode] - 5'd1);
  assign first_bit = (col_cnt == '0) && (row_cnt == '0);

  // Row-major word index
  assign addr.raw = {row_cnt, col_cnt};

  // One when decoding flipped the channel decision
  assign err_inc = {{(btc_buf_pkg::cERR_W-1){1'b0}}, ibit ^ ihard};

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      col_cnt  <= '0;
      row_cnt  <= '0;
      wr.wval  <= 1'b0;
      wr.wdone <= 1'b0;
    end else if (iclkena) begin
      wr.wval  <= ival;
      wr.wdone <= ival & col_last & row_last;
      if (ival) begin
        if (col_last) begin
          col_cnt <= '0;
          // Wrap to row 0 after the last row
          row_cnt <= row_last ? '0 : row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  // --------------------------------------
  // Write data and block descriptor
  // --------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      wr.waddr <= addr;
      wr.wdat  <= ibit;
      // Error count restarts on the first bit
      wr.werr  <= first_bit ? err_inc : wr.werr + err_inc;
      if (first_bit) begin
        wr.wtag     <= itag;
        wr.wdecfail <= idecfail;
      end
    end
  end

  // Blocked from the last write until the sink frees the buffer
  assign ordy = ~(wr.full | wr.wdone);

  // Source honors ordy
  a_no_val_when_full : assert property (
    @(posedge iclk) disable iff (ireset) (iclkena && ival) |-> !wr.full
  );

endmodule

//--- hdl/btc_dec_out.sv
// BTC decoder output subsystem
`timescale 1ns/1ns

module btc_dec_out (
  input  logic                           iclk,
  input  logic                           ireset,
  input  logic                           iclkena,
  input  btc_mode_pkg::btc_code_mode_t   ixmode,
  input  btc_mode_pkg::btc_code_mode_t   iymode,
  // Decoder side
  input  logic                           ival,
  input  logic                           ibit,
  input  logic                           ihard,
  input  logic [btc_buf_pkg::cTAG_W-1:0] itag,
  input  logic                           idecfail,
  output logic                           ordy,
  // Output side
  input  logic                           ireq,
  output logic                           ofull,
  output logic                           oval,
  output logic                           osop,
  output logic                           oeop,
  output logic                           odat,
  output logic [btc_buf_pkg::cTAG_W-1:0] otag,
  output logic                           odecfail,
  output logic [btc_buf_pkg::cERR_W-1:0] oerr,
  output logic [btc_buf_pkg::cERR_W-1:0] onum
);

  btc_buf_wr_if wr_if ();
  btc_buf_rd_if rd_if ();

  // Decoder bits into the buffer
  btc_buf_writer writer_i (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ixmode   (ixmode),
    .iymode   (iymode),
    .ival     (ival),
    .ibit     (ibit),
    .ihard    (ihard),
    .idecfail (idecfail),
    .itag     (itag),
    .ordy     (ordy),
    .wr       (wr_if.writer)
  );

  btc_out_buffer buffer_i (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .wr      (wr_if.buffer),
    .rd      (rd_if.buffer)
  );

  // Buffer out as a framed serial stream
  btc_dec_sink sink_i (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ixmode   (ixmode),
    .iymode   (iymode),
    .ireq     (ireq),
    .rd       (rd_if.sink),
    .ofull    (ofull),
    .oval     (oval),
    .osop     (osop),
    .oeop     (oeop),
    .odat     (odat),
    .odecfail (odecfail),
    .otag     (otag),
    .oerr     (oerr),
    .onum     (onum)
  );

endmodule

//--- hdl/btc_dec_sink.sv
// BTC decoder serial output sink
`timescale 1ns/1ns

module btc_dec_sink (
  input  logic                           iclk,
  input  logic                           ireset,
  input  logic                           iclkena,
  input  btc_mode_pkg::btc_code_mode_t   ixmode,
  input  btc_mode_pkg::btc_code_mode_t   iymode,
  input  logic                           ireq,
  btc_buf_rd_if.sink                     rd,
  output logic                           ofull,
  output logic                           oval,
  output logic                           osop,
  output logic                           oeop,
  output logic                           odat,
  output logic                           odecfail,
  output logic [btc_buf_pkg::cTAG_W-1:0] otag,
  output logic [btc_buf_pkg::cERR_W-1:0] oerr,
  output logic [btc_buf_pkg::cERR_W-1:0] onum
);

  // FSM, idle when low and reading when high
  logic busy;
  logic start;
  logic rd_req;
  logic work_done;

  // Counters with done flags one step ahead
  logic [btc_mode_pkg::cLOG2_COL_MAX-1:0] col_idx;
  logic                                   col_done;
  logic [btc_mode_pkg::cLOG2_COL_MAX-1:0] col_len_m2;
  logic [btc_mode_pkg::cLOG2_ROW_MAX-1:0] row_idx;
  logic                                   row_done;
  logic [btc_mode_pkg::cLOG2_ROW_MAX-1:0] row_len_m2;

  btc_buf_pkg::btc_addr_u                 raddr;

  // Request pipes, buffer latency plus output register
  logic [btc_buf_pkg::cRD_LAT:0]          val_sr;
  logic [btc_buf_pkg::cRD_LAT:0]          eop_sr;

  // Start delayed to the ofull edge
  logic                                   start_d;

  // --------------------------------------
  // FSM and address counters
  // --------------------------------------

  assign start     = ~busy & rd.rfull;
  assign rd_req    = busy & ireq;
  assign work_done = col_done & row_done;

  // Last request of the block frees the buffer
  assign rd.rempty = rd_req & work_done;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy       <= 1'b0;
      col_idx    <= '0;
      col_done   <= 1'b0;
      col_len_m2 <= '0;
      row_idx    <= '0;
      row_done   <= 1'b0;
      row_len_m2 <= '0;
    end else if (iclkena) begin
      if (!busy) begin
        busy       <= rd.rfull;
        col_idx    <= '0;
        col_done   <= 1'b0;
        row_idx    <= '0;
        row_done   <= 1'b0;
        // Lengths minus two, done is flagged one step early
        col_len_m2 <= btc_mode_pkg::cDATA_BITS[ixmode] - 5'd2;
        row_len_m2 <= btc_mode_pkg::cDATA_BITS[iymode] - 5'd2;
      end else if (ireq) begin
        busy     <= ~work_done;
        col_idx  <= col_done ? '0 : col_idx + 1'b1;
        col_done <= (col_idx == col_len_m2);
        // Next row on column wrap
        if (col_done) begin
          row_idx  <= row_idx + 1'b1;
          row_done <= (row_idx == row_len_m2);
        end
      end
    end
  end

  always_comb begin
    raddr.rc.row = row_idx;
    raddr.rc.col = col_idx;
  end

  assign rd.raddr = raddr;

  // --------------------------------------
  // Output framing
  // --------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_sr  <= '0;
      eop_sr  <= '0;
      start_d <= 1'b0;
      ofull   <= 1'b0;
      osop    <= 1'b0;
    end else if (iclkena) begin
      val_sr  <= {val_sr[btc_buf_pkg::cRD_LAT-1:0], rd_req};
      eop_sr  <= {eop_sr[btc_buf_pkg::cRD_LAT-1:0], rd.rempty};
      start_d <= start;
      if (start_d) begin
        ofull <= 1'b1;
      end else if (rd.rempty) begin
        ofull <= 1'b0;
      end
      // Held until the first bit goes out
      if (start_d) begin
        osop <= 1'b1;
      end else if (oval) begin
        osop <= 1'b0;
      end
    end
  end

  assign oval = val_sr[btc_buf_pkg::cRD_LAT];
  assign oeop = eop_sr[btc_buf_pkg::cRD_LAT];

  // Data register and block info
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      odat <= rd.rdat;
      if (start) begin
        otag     <= rd.rtag;
        odecfail <= rd.rdecfail;
        oerr     <= rd.rerr;
        onum     <= btc_mode_pkg::cDATA_ERR_BIT_SIZE[{iymode, ixmode}];
      end
    end
  end

  // End strobe rides on a valid bit, after the buffer is released
  a_eop_with_val : assert property (
    @(posedge iclk) disable iff (ireset) oeop |-> oval && !ofull
  );

endmodule

//--- hdl/btc_mode_pkg.sv
// BTC code mode definitions

package btc_mode_pkg;

  // --------------------------------------
  // Component code modes
  // --------------------------------------

  // Extended Hamming and parity codes
  typedef enum logic [1:0] {
    cCODE_8_4   = 2'd0,
    cCODE_8_7   = 2'd1,
    cCODE_16_11 = 2'd2,
    cCODE_32_26 = 2'd3
  } btc_code_mode_t;

  // Row and column index widths
  localparam int cLOG2_COL_MAX = 5;
  localparam int cLOG2_ROW_MAX = 5;

  // --------------------------------------
  // Per-mode lookup tables
  // --------------------------------------

  // Data bits per component code, by mode
  localparam logic [4:0] cDATA_BITS [4] = '{5'd4, 5'd7, 5'd11, 5'd26};

  // Data bits per block
  // Index is {ymode, xmode}, entry is ky * kx
  localparam logic [15:0] cDATA_ERR_BIT_SIZE [16] = '{
    // y = 8_4
    16'd16,  16'd28,  16'd44,  16'd104,
    // y = 8_7
    16'd28,  16'd49,  16'd77,  16'd182,
    // y = 16_11
    16'd44,  16'd77,  16'd121, 16'd286,
    // y = 32_26
    16'd104, 16'd182, 16'd286, 16'd676
  };

endpackage

//--- hdl/btc_out_buffer.sv
// BTC single result buffer
`timescale 1ns/1ns

module btc_out_buffer (
  input  logic         iclk,
  input  logic         ireset,
  input  logic         iclkena,
  btc_buf_wr_if.buffer wr,
  btc_buf_rd_if.buffer rd
);

  // One bit per word
  logic                             mem [2**btc_buf_pkg::cRADDR_W];
  logic [btc_buf_pkg::cRADDR_W-1:0] raddr_q;
  logic                             rdat_q;

  // Descriptor of the stored block
  logic [btc_buf_pkg::cTAG_W-1:0]   tag_q;
  logic [btc_buf_pkg::cERR_W-1:0]   err_q;
  logic                             decfail_q;

  logic                             full;

  // --------------------------------------
  // Bit memory
  // --------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && wr.wval) begin
      mem[wr.waddr.raw] <= wr.wdat;
    end
  end

  // Address stage then data stage
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      raddr_q <= rd.raddr.raw;
      rdat_q  <= mem[raddr_q];
    end
  end

  assign rd.rdat = rdat_q;

  // --------------------------------------
  // Descriptor and full flag
  // --------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && wr.wdone) begin
      tag_q     <= wr.wtag;
      err_q     <= wr.werr;
      decfail_q <= wr.wdecfail;
    end
  end

  // Set after the last write, cleared when the sink is done
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      full <= 1'b0;
    end else if (iclkena) begin
      if (rd.rempty) begin
        full <= 1'b0;
      end else if (wr.wdone) begin
        full <= 1'b1;
      end
    end
  end

  assign wr.full     = full;
  assign rd.rfull    = full;
  assign rd.rtag     = tag_q;
  assign rd.rerr     = err_q;
  assign rd.rdecfail = decfail_q;

  // Writer must not finish a block over an unread one
  a_no_done_when_full : assert property (
    @(posedge iclk) disable iff (ireset) (iclkena && wr.wdone) |-> !full
  );

  // Sink only releases a held block
  a_empty_only_full : assert property (
    @(posedge iclk) disable iff (ireset) (iclkena && rd.rempty) |-> full
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the BTC output testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module btc_dec_out_tb -o btc_dec_out_sim

# The simulator exit status is ignored here, the log decides
./obj_dir/btc_dec_out_sim 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
elif ! grep -q "All checks passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

//--- sim/btc_tb_checks.svh
// Typed output compare tasks
`ifndef BTC_TB_CHECKS_SVH
`define BTC_TB_CHECKS_SVH

// --------------------------------------
// One task per kind of result
// --------------------------------------

// Serial data bit
task compare_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("MISMATCH time %0t %s got %b expected %b", $time, name, got, exp);
    abort_run();
  end
endtask

// Block tag
task verify_tag(input string name, input logic [btc_buf_pkg::cTAG_W-1:0] got,
                input logic [btc_buf_pkg::cTAG_W-1:0] exp);
  if (got !== exp) begin
    $display("MISMATCH time %0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
    abort_run();
  end
endtask

// Error count or bit count
task match_count(input string name, input logic [btc_buf_pkg::cERR_W-1:0] got,
                 input logic [btc_buf_pkg::cERR_W-1:0] exp);
  if (got !== exp) begin
    $display("MISMATCH time %0t %s got %0d expected %0d", $time, name, got, exp);
    abort_run();
  end
endtask

// Strobes and levels
task test_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("MISMATCH time %0t %s got %b expected %b", $time, name, got, exp);
    abort_run();
  end
endtask

`endif

//--- sim/btc_dec_out_tb.sv
// BTC decoder output testbench
`timescale 1ns/1ns

module btc_dec_out_tb;

  localparam int cBLOCKS       = 6;
  localparam int cRESET_CYCLES = 8;

  logic iclk;
  logic ireset;
  logic iclkena;
  btc_mode_pkg::btc_code_mode_t ixmode;
  btc_mode_pkg::btc_code_mode_t iymode;
  logic ival;
  logic ibit;
  logic ihard;
  logic [btc_buf_pkg::cTAG_W-1:0] itag;
  logic idecfail;
  logic ordy;
  logic ireq;
  logic ofull;
  logic oval;
  logic osop;
  logic oeop;
  logic odat;
  logic [btc_buf_pkg::cTAG_W-1:0] otag;
  logic odecfail;
  logic [btc_buf_pkg::cERR_W-1:0] oerr;
  logic [btc_buf_pkg::cERR_W-1:0] onum;

  // --------------------------------------
  // Block table, one row per block
  // --------------------------------------

  btc_mode_pkg::btc_code_mode_t tab_x [cBLOCKS] = '{
    btc_mode_pkg::cCODE_8_4, btc_mode_pkg::cCODE_8_7, btc_mode_pkg::cCODE_32_26,
    btc_mode_pkg::cCODE_16_11, btc_mode_pkg::cCODE_32_26, btc_mode_pkg::cCODE_8_7};
  btc_mode_pkg::btc_code_mode_t tab_y [cBLOCKS] = '{
    btc_mode_pkg::cCODE_8_4, btc_mode_pkg::cCODE_16_11, btc_mode_pkg::cCODE_8_4,
    btc_mode_pkg::cCODE_8_7, btc_mode_pkg::cCODE_32_26, btc_mode_pkg::cCODE_8_7};
  logic [btc_buf_pkg::cTAG_W-1:0] tab_tag [cBLOCKS] = '{
    8'h3C, 8'hA5, 8'h01, 8'hFE, 8'h5A, 8'h7E};
  logic tab_fail [cBLOCKS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
  // Last block has every hard bit flipped
  int tab_flips [cBLOCKS] = '{0, 3, 10, 1, 25, 49};

  // Expected stream, filled by the driver
  logic exp_bits [$];
  logic [btc_buf_pkg::cTAG_W-1:0] exp_tag [$];
  logic exp_fail [$];
  logic [btc_buf_pkg::cERR_W-1:0] exp_err [$];
  logic [btc_buf_pkg::cERR_W-1:0] exp_num [$];

  integer seed     = 51;
  integer req_seed = 51;
  int     blocks_done = 0;

  btc_dec_out dut_i (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .ixmode (ixmode), .iymode (iymode),
    .ival (ival), .ibit (ibit), .ihard (ihard), .itag (itag), .idecfail (idecfail),
    .ordy (ordy), .ireq (ireq),
    .ofull (ofull), .oval (oval), .osop (osop), .oeop (oeop), .odat (odat),
    .otag (otag), .odecfail (odecfail), .oerr (oerr), .onum (onum)
  );

  initial begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;
  end

  task abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "btc_tb_checks.svh"

  // Data bits per component code
  function automatic int data_bits_of(input btc_mode_pkg::btc_code_mode_t mode);
    case (mode)
      btc_mode_pkg::cCODE_8_4:   data_bits_of = 4;
      btc_mode_pkg::cCODE_8_7:   data_bits_of = 7;
      btc_mode_pkg::cCODE_16_11: data_bits_of = 11;
      default:                   data_bits_of = 26;
    endcase
  endfunction

  function automatic int total_bits();
    int sum;
    sum = 0;
    for (int b = 0; b < cBLOCKS; b++) begin
      sum += data_bits_of(tab_x[b]) * data_bits_of(tab_y[b]);
    end
    return sum;
  endfunction

  // --------------------------------------
  // Decoder side driver
  // --------------------------------------

  // Hold off while the buffer is busy
  task wait_ready();
    while (!ordy) begin
      ival = 1'b0;
      @(posedge iclk);
      #1;
    end
  endtask

  task drive_block(input int b);
    int size;
    int remaining;
    int err_cnt;
    logic [31:0] rnd;
    logic bit_v;
    logic flip;
    size = data_bits_of(tab_x[b]) * data_bits_of(tab_y[b]);
    remaining = tab_flips[b];
    err_cnt = 0;
    wait_ready();
    // Modes change only once the sink has taken the previous block
    ixmode = tab_x[b];
    iymode = tab_y[b];
    for (int i = 0; i < size; i++) begin
      wait_ready();
      rnd = $random(seed);
      bit_v = rnd[0];
      // Selection sampling, exactly tab_flips positions
      rnd = $random(seed);
      flip = ($unsigned(rnd) % (size - i)) < remaining;
      if (flip) begin
        remaining--;
        err_cnt++;
      end
      ival  = 1'b1;
      ibit  = bit_v;
      ihard = bit_v ^ flip;
      // Tag and fail flag only count with the first bit
      itag     = (i == 0) ? tab_tag[b] : ~tab_tag[b];
      idecfail = (i == 0) ? tab_fail[b] : ~tab_fail[b];
      exp_bits.push_back(bit_v);
      @(posedge iclk);
      #1;
    end
    ival = 1'b0;
    // Last write blocks the source
    test_flag("ordy", ordy, 1'b0);
    exp_tag.push_back(tab_tag[b]);
    exp_fail.push_back(tab_fail[b]);
    exp_err.push_back(err_cnt[btc_buf_pkg::cERR_W-1:0]);
    exp_num.push_back(size[btc_buf_pkg::cERR_W-1:0]);
  endtask

  // --------------------------------------
  // Output side, requests and scoreboard
  // --------------------------------------

  task drive_requests();
    logic [31:0] rnd;
    forever begin
      @(posedge iclk);
      #1;
      rnd = $random(req_seed);
      // About one gap in four cycles
      ireq = (rnd[1:0] != 2'b00);
    end
  endtask

  task collect_stream();
    logic ofull_prev;
    logic block_open;
    int   bit_pos;
    int   cur_size;
    logic [btc_buf_pkg::cTAG_W-1:0] cur_tag;
    logic cur_fail;
    logic [btc_buf_pkg::cERR_W-1:0] cur_err;
    ofull_prev = 1'b0;
    block_open = 1'b0;
    bit_pos = 0;
    cur_size = 0;
    forever begin
      @(negedge iclk);
      // New block announced
      if (ofull && !ofull_prev) begin
        if (exp_tag.size() == 0 || block_open) begin
          $display("ERROR: ofull rose at %0t without a complete block waiting", $time);
          abort_run();
        end else begin
          cur_tag  = exp_tag.pop_front();
          cur_fail = exp_fail.pop_front();
          cur_err  = exp_err.pop_front();
          match_count("onum", onum, exp_num[0]);
          cur_size = int'(exp_num.pop_front());
          block_open = 1'b1;
        end
      end
      ofull_prev = ofull;
      if (ofull) begin
        verify_tag("otag", otag, cur_tag);
        test_flag("odecfail", odecfail, cur_fail);
        match_count("oerr", oerr, cur_err);
        match_count("onum", onum, cur_size[btc_buf_pkg::cERR_W-1:0]);
      end
      test_flag("osop", osop, block_open && bit_pos == 0);
      test_flag("oeop", oeop, oval && block_open && bit_pos == cur_size - 1);
      if (oval) begin
        if (!block_open || exp_bits.size() == 0) begin
          $display("ERROR: oval at %0t with no bit left to read", $time);
          abort_run();
        end else begin
          compare_bit("odat", odat, exp_bits.pop_front());
          bit_pos++;
          if (bit_pos == cur_size) begin
            // Tail bits come out after ofull has dropped
            test_flag("ofull", ofull, 1'b0);
            bit_pos = 0;
            block_open = 1'b0;
            blocks_done++;
          end
        end
      end
    end
  endtask

  // Budget from the table
  initial begin
    int limit;
    limit = cRESET_CYCLES + 8 * total_bits();
    repeat (limit) @(posedge iclk);
    $display("ERROR: timeout after %0d clock cycles, output stream incomplete", limit);
    abort_run();
  end

  initial begin
    ireset   = 1'b1;
    iclkena  = 1'b1;
    ixmode   = tab_x[0];
    iymode   = tab_y[0];
    ival     = 1'b0;
    ibit     = 1'b0;
    ihard    = 1'b0;
    itag     = '0;
    idecfail = 1'b0;
    ireq     = 1'b0;
    repeat (cRESET_CYCLES) @(posedge iclk);
    #1;
    ireset = 1'b0;
    // Idle state before any stimulus
    @(negedge iclk);
    test_flag("ofull", ofull, 1'b0);
    test_flag("oval", oval, 1'b0);
    test_flag("osop", osop, 1'b0);
    test_flag("oeop", oeop, 1'b0);
    test_flag("ordy", ordy, 1'b1);
    @(posedge iclk);
    #1;
    fork
      drive_requests();
      collect_stream();
    join_none
    for (int b = 0; b < cBLOCKS; b++) begin
      drive_block(b);
    end
    wait (blocks_done == cBLOCKS);
    // Nothing extra may follow the last block
    repeat (8) @(negedge iclk);
    test_flag("ofull", ofull, 1'b0);
    if (exp_bits.size() != 0) begin
      $display("ERROR: %0d driven bits never came out", exp_bits.size());
      abort_run();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- src.f
+incdir+sim
hdl/btc_mode_pkg.sv
hdl/btc_buf_pkg.sv
hdl/btc_buf_if.sv
hdl/btc_buf_writer.sv
hdl/btc_out_buffer.sv
hdl/btc_dec_sink.sv
hdl/btc_dec_out.sv
sim/btc_dec_out_tb.sv
